//--- common/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// ========================================
// raster geometry
// ========================================

// horizontal timing in clocks per line
`define VID_H_ACTIVE 32
`define VID_H_TOTAL 48

// hsync asserted for pixels 36 through 39
`define VID_HS_START 36
`define VID_HS_END 40

// vertical timing in lines per frame
`define VID_V_ACTIVE 8
`define VID_V_TOTAL 12

// vsync covers line 9 only
`define VID_VS_START 9
`define VID_VS_END 10

// ========================================
// memory side
// ========================================

// word address width of the external memory port
`define VID_ADDR_W 16

// line buffer holds 2**5 = 32 words, one whole frame
`define VID_FIFO_AW 5

// cap on reads in flight at the memory port
`define VID_FETCH_MAX_OUT 4

`endif

//--- common/video_pkg.sv
`default_nettype none

`include "video_macros.svh"

package video_pkg;

	// ========================================
	// pixel and word layout
	// ========================================

	// bits per pixel
	localparam int PIX_W = 16;

	// pixels packed into one memory word
	localparam int PIX_PER_WORD = 8;

	// bits needed to count lanes inside a word
	localparam int LANE_W = $clog2(PIX_PER_WORD);

	// one pixel, plain 16 bit value
	typedef logic [PIX_W-1:0] pixel_t;

	// one memory word
	// lane 0 sits in the low 16 bits, lane 7 in the top 16
	typedef logic [PIX_PER_WORD*PIX_W-1:0] vid_word_t;

	// word address into the frame memory
	typedef logic [`VID_ADDR_W-1:0] vid_addr_t;

	// ========================================
	// derived frame sizes
	// ========================================

	// words fetched for one displayed frame
	localparam int FRAME_WORDS = (`VID_H_ACTIVE * `VID_V_ACTIVE) / PIX_PER_WORD;

endpackage

`default_nettype wire

//--- video_fifo/video_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module video_fifo import video_pkg::*; #(
	parameter int AW = `VID_FIFO_AW
) (
	input  logic      rclk,
	input  logic      rrst,
	input  logic      wr,
	input  vid_word_t di,
	input  logic      rd,
	output vid_word_t dout,
	output logic [AW:0] cnt
);

	localparam int DEPTH = 1 << AW;

	// ========================================
	// storage and pointers
	// ========================================

	// line buffer words
	vid_word_t mem [DEPTH];

	// pointers carry one extra bit
	// equal low bits with different top bit means full
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	// registered read address, the head of the buffer
	logic [AW-1:0] rd_addr;

	// write side
	always_ff @(posedge rclk) begin
		if (rrst) begin
			wr_ptr <= '0;
		end else if (wr) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// storage write, no reset on the array
	always_ff @(posedge rclk) begin
		if (wr) begin
			mem[wr_ptr[AW-1:0]] <= di;
		end
	end

	// read side
	// pointer and head address step together on a pop
	always_ff @(posedge rclk) begin
		if (rrst) begin
			rd_ptr <= '0;
			rd_addr <= '0;
		end else if (rd) begin
			rd_ptr <= rd_ptr + 1'b1;
			rd_addr <= rd_addr + 1'b1;
		end
	end

	// head word is always on dout
	// a write into an empty buffer shows up here the next cycle
	assign dout = mem[rd_addr];

	// level from the pointer difference
	// wraps correctly thanks to the extra bit
	assign cnt = wr_ptr - rd_ptr;

endmodule

`default_nettype wire

//--- rtl/video_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module video_fetch import video_pkg::*; (
	input  logic      rclk,
	input  logic      rrst,
	input  logic      enable,
	input  vid_addr_t frame_base,
	input  logic      frame_start,
	input  logic [`VID_FIFO_AW:0] fifo_cnt,
	output logic      mem_req,
	output vid_addr_t mem_addr,
	input  logic      mem_ack,
	output logic      fifo_wr
);

	localparam int FIFO_DEPTH = 1 << `VID_FIFO_AW;
	localparam int CNT_W = `VID_FIFO_AW + 1;
	localparam int SUM_W = CNT_W + 1;
	localparam int OUT_W = $clog2(`VID_FETCH_MAX_OUT + 1);
	localparam int WCNT_W = $clog2(FRAME_WORDS + 1);

	// ========================================
	// request bookkeeping
	// ========================================

	// next word address to ask for
	vid_addr_t addr;

	// words requested so far in this frame
	logic [WCNT_W-1:0] issued;

	// reads sent but not yet answered
	logic [OUT_W-1:0] outstanding;

	// counts that include a request on the port this cycle
	logic [WCNT_W-1:0] issued_now;
	logic [OUT_W-1:0] pending;

	// buffer words plus words still on their way
	logic [SUM_W-1:0] committed;

	logic req_next;

	assign issued_now = issued + WCNT_W'(mem_req);
	assign pending = outstanding + OUT_W'(mem_req);
	assign committed = SUM_W'(fifo_cnt) + SUM_W'(pending);

	// ask for another word only when it is sure to fit
	assign req_next = enable && !frame_start
		&& (issued_now < WCNT_W'(FRAME_WORDS))
		&& (pending < OUT_W'(`VID_FETCH_MAX_OUT))
		&& (committed < SUM_W'(FIFO_DEPTH));

	// strobe and control counters
	// idle after reset until the first frame_start
	always_ff @(posedge rclk) begin
		if (rrst) begin
			mem_req <= 1'b0;
			issued <= WCNT_W'(FRAME_WORDS);
		end else begin
			mem_req <= req_next;
			if (frame_start) begin
				issued <= '0;
			end else if (mem_req) begin
				issued <= issued + 1'b1;
			end
		end
	end

	// reads in flight, up on a request and down on a reply
	always_ff @(posedge rclk) begin
		if (rrst) begin
			outstanding <= '0;
		end else begin
			case ({mem_req, mem_ack})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	// address walk, payload only
	always_ff @(posedge rclk) begin
		if (frame_start) begin
			addr <= frame_base;
		end else if (req_next) begin
			mem_addr <= addr;
			addr <= addr + 1'b1;
		end
	end

	// replies come back in order, straight into the buffer
	assign fifo_wr = mem_ack;

endmodule

`default_nettype wire

//--- rtl/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module video_timing (
	input  logic rclk,
	input  logic rrst,
	output logic de,
	output logic hsync,
	output logic vsync,
	output logic frame_start
);

	localparam int H_W = $clog2(`VID_H_TOTAL);
	localparam int V_W = $clog2(`VID_V_TOTAL);

	// ========================================
	// raster counters
	// ========================================

	// pixel position within the line
	logic [H_W-1:0] h_cnt;

	// line position within the frame
	logic [V_W-1:0] v_cnt;

	logic h_last;
	logic v_last;

	assign h_last = (h_cnt == H_W'(`VID_H_TOTAL - 1));
	assign v_last = (v_cnt == V_W'(`VID_V_TOTAL - 1));

	// free running, line counter steps at end of each line
	always_ff @(posedge rclk) begin
		if (rrst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// ========================================
	// decoded outputs
	// ========================================

	logic h_act;
	logic v_act;
	logic hs_win;
	logic vs_win;

	assign h_act = (h_cnt < H_W'(`VID_H_ACTIVE));
	assign v_act = (v_cnt < V_W'(`VID_V_ACTIVE));
	assign hs_win = (h_cnt >= H_W'(`VID_HS_START)) && (h_cnt < H_W'(`VID_HS_END));
	assign vs_win = (v_cnt >= V_W'(`VID_VS_START)) && (v_cnt < V_W'(`VID_VS_END));

	// all four registered off the same count, so they stay in step
	always_ff @(posedge rclk) begin
		if (rrst) begin
			de <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			de <= h_act && v_act;
			hsync <= hs_win;
			vsync <= vs_win;
			// first clock of the first blank line
			frame_start <= (h_cnt == '0) && (v_cnt == V_W'(`VID_V_ACTIVE));
		end
	end

endmodule

`default_nettype wire

//--- rtl/pixel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module pixel_shifter import video_pkg::*; (
	input  logic      rclk,
	input  logic      rrst,
	input  logic      de,
	input  logic      frame_start,
	input  vid_word_t fifo_dout,
	input  logic [`VID_FIFO_AW:0] fifo_cnt,
	output logic      fifo_rd,
	output pixel_t    pixel,
	output logic      pix_de,
	output logic      underflow
);

	// ========================================
	// lane sequencing
	// ========================================

	// held low until the first frame_start
	logic started;

	// which 16 bit lane of the head word goes out next
	logic [LANE_W-1:0] lane;

	// the word now being shifted really came from the buffer
	logic word_ok;

	logic run;
	logic need_word;
	logic cur_ok;
	logic last_lane;

	assign run = de && started;
	assign need_word = (lane == '0);
	assign last_lane = (lane == LANE_W'(PIX_PER_WORD - 1));

	// on lane 0 look at the buffer, later lanes reuse the verdict
	assign cur_ok = need_word ? (fifo_cnt != '0) : word_ok;

	// pop after the last lane, only if a real word was used
	assign fifo_rd = run && cur_ok && last_lane;

	always_ff @(posedge rclk) begin
		if (rrst) begin
			started <= 1'b0;
			lane <= '0;
			word_ok <= 1'b0;
			pix_de <= 1'b0;
			underflow <= 1'b0;
		end else begin
			if (frame_start) begin
				started <= 1'b1;
			end
			// lane counter wraps by itself after lane 7
			if (frame_start) begin
				lane <= '0;
			end else if (run) begin
				lane <= lane + 1'b1;
			end
			if (run && need_word) begin
				word_ok <= cur_ok;
			end
			// sticky until reset
			if (run && need_word && !cur_ok) begin
				underflow <= 1'b1;
			end
			pix_de <= run;
		end
	end

	// pixel data, one cycle behind de
	// a missing word goes out as black
	always_ff @(posedge rclk) begin
		if (run) begin
			if (cur_ok) begin
				pixel <= fifo_dout[lane*PIX_W +: PIX_W];
			end else begin
				pixel <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/video_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module video_top import video_pkg::*; (
	input  logic      rclk,
	input  logic      rrst,
	input  logic      enable,
	input  vid_addr_t frame_base,
	output logic      mem_req,
	output vid_addr_t mem_addr,
	input  logic      mem_ack,
	input  vid_word_t mem_rdata,
	output pixel_t    pixel,
	output logic      pix_de,
	output logic      hsync,
	output logic      vsync,
	output logic      underflow
);

	// ========================================
	// internal nets
	// ========================================

	logic fifo_wr;
	logic fifo_rd;
	vid_word_t fifo_dout;
	logic [`VID_FIFO_AW:0] fifo_cnt;

	// raw timing, one cycle ahead of the outputs
	logic tim_de;
	logic tim_hsync;
	logic tim_vsync;
	logic frame_start;

	video_fetch u_fetch (
		.rclk        (rclk),
		.rrst        (rrst),
		.enable      (enable),
		.frame_base  (frame_base),
		.frame_start (frame_start),
		.fifo_cnt    (fifo_cnt),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.fifo_wr     (fifo_wr)
	);

	// memory reply data goes straight into the line buffer
	video_fifo #(
		.AW (`VID_FIFO_AW)
	) u_fifo (
		.rclk (rclk),
		.rrst (rrst),
		.wr   (fifo_wr),
		.di   (mem_rdata),
		.rd   (fifo_rd),
		.dout (fifo_dout),
		.cnt  (fifo_cnt)
	);

	video_timing u_timing (
		.rclk        (rclk),
		.rrst        (rrst),
		.de          (tim_de),
		.hsync       (tim_hsync),
		.vsync       (tim_vsync),
		.frame_start (frame_start)
	);

	pixel_shifter u_shifter (
		.rclk        (rclk),
		.rrst        (rrst),
		.de          (tim_de),
		.frame_start (frame_start),
		.fifo_dout   (fifo_dout),
		.fifo_cnt    (fifo_cnt),
		.fifo_rd     (fifo_rd),
		.pixel       (pixel),
		.pix_de      (pix_de),
		.underflow   (underflow)
	);

	// syncs take the same one cycle as the shifter
	always_ff @(posedge rclk) begin
		if (rrst) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			hsync <= tim_hsync;
			vsync <= tim_vsync;
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic rclk,
	output logic rrst
);

	// free running clock, 100 ns period
	initial begin
		rclk = 1'b0;
		forever begin
			#50 rclk = ~rclk;
		end
	end

	// reset held over two rising edges, dropped on a falling edge
	initial begin
		rrst = 1'b1;
		repeat (2) @(posedge rclk);
		@(negedge rclk);
		rrst = 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/tb_video_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module tb_video_top import video_pkg::*; ();

	localparam int FRAME_CYC = `VID_H_TOTAL * `VID_V_TOTAL;
	// raster position where the DUT fetch for the next frame starts
	localparam int FETCH_POS = `VID_V_ACTIVE * `VID_H_TOTAL;
	localparam int MEM_WORDS = 256;
	localparam int WAIT_LIMIT = 3 * FRAME_CYC;
	localparam vid_addr_t BASE_A = 16'h0010;
	// second base runs past the end of the model memory and wraps
	localparam vid_addr_t BASE_B = 16'h01e8;

	logic rclk;
	logic rrst;
	logic enable;
	vid_addr_t frame_base;
	logic mem_req;
	vid_addr_t mem_addr;
	logic mem_ack;
	vid_word_t mem_rdata;
	pixel_t pixel;
	logic pix_de;
	logic hsync;
	logic vsync;
	logic underflow;

	// ========================================
	// clock, reset and DUT
	// ========================================

	tb_clock u_clock (
		.rclk (rclk),
		.rrst (rrst)
	);

	video_top u_dut (
		.rclk       (rclk),
		.rrst       (rrst),
		.enable     (enable),
		.frame_base (frame_base),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata),
		.pixel      (pixel),
		.pix_de     (pix_de),
		.hsync      (hsync),
		.vsync      (vsync),
		.underflow  (underflow)
	);

	// rising edges seen since reset was released
	int clk_count;

	always @(posedge rclk) begin
		if (rrst) begin
			clk_count <= 0;
		end else begin
			clk_count <= clk_count + 1;
		end
	end

	// ========================================
	// failure reporting
	// ========================================

	integer seed;
	vid_word_t mem [MEM_WORDS];

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic report_error(input string msg);
		stop_with_failure($sformatf("Error at %0d ns: %s", $time, msg));
	endtask

	// one 16 bit lane out of a memory word with lane 0 at the bottom
	function automatic pixel_t lane_of(input vid_word_t w, input int idx);
		vid_word_t s;
		s = w >> (idx * PIX_W);
		return s[PIX_W-1:0];
	endfunction

	// ========================================
	// memory model
	// ========================================

	// replies in request order after 1 to 6 cycles
	initial begin : memory_model
		int i;
		int cyc;
		int delay;
		int due;
		int last_due;
		int due_q[$];
		vid_addr_t addr_q[$];
		seed = 54415;
		mem_ack = 1'b0;
		mem_rdata = '0;
		cyc = 0;
		last_due = 0;
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[8'(i)] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		end
		forever begin
			@(negedge rclk);
			cyc = cyc + 1;
			mem_ack = 1'b0;
			mem_rdata = '0;
			if (due_q.size() > 0 && due_q[0] == cyc) begin
				mem_ack = 1'b1;
				mem_rdata = mem[addr_q[0][7:0]];
				void'(due_q.pop_front());
				void'(addr_q.pop_front());
			end
			if (mem_req === 1'b1) begin
				delay = 1 + int'({$random(seed)} % 6);
				due = cyc + delay;
				// one reply per cycle keeps them in order
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				due_q.push_back(due);
				addr_q.push_back(mem_addr);
			end
		end
	end

	// ========================================
	// output checker
	// ========================================

	vid_addr_t fetch_base;
	logic fetch_on;
	int fetch_idx;
	vid_addr_t disp_base;
	logic disp_on;
	logic exp_uf;

	// outputs trail the raster counters by two clocks
	always @(negedge rclk) begin : check_outputs
		int p;
		int hpos;
		int vpos;
		int n;
		logic exp_de;
		logic exp_hs;
		logic exp_vs;
		pixel_t exp_pix;
		vid_addr_t waddr;
		if (clk_count == 0) begin
			fetch_base = '0;
			fetch_on = 1'b0;
			fetch_idx = 0;
			disp_base = '0;
			disp_on = 1'b0;
			exp_uf = 1'b0;
		end else begin
			p = clk_count - 2;
			hpos = -1;
			vpos = -1;
			exp_de = 1'b0;
			exp_hs = 1'b0;
			exp_vs = 1'b0;
			if (p >= 0) begin
				hpos = p % `VID_H_TOTAL;
				vpos = (p / `VID_H_TOTAL) % `VID_V_TOTAL;
				// the whole frame must be fetched by the time it starts
				if (p % FRAME_CYC == 0) begin
					if (fetch_on) begin
						assert (fetch_idx == FRAME_WORDS)
						else report_error($sformatf("only %0d words fetched", fetch_idx));
					end
					disp_base = fetch_base;
					disp_on = fetch_on;
				end
				// the DUT takes base and enable on the first blank line
				if (p % FRAME_CYC == FETCH_POS) begin
					fetch_base = frame_base;
					fetch_on = enable;
					fetch_idx = 0;
				end
				// nothing is shown before the first frame_start
				exp_de = (p >= FRAME_CYC) && (hpos < `VID_H_ACTIVE)
					&& (vpos < `VID_V_ACTIVE);
				exp_hs = (hpos >= `VID_HS_START) && (hpos < `VID_HS_END);
				exp_vs = (vpos >= `VID_VS_START) && (vpos < `VID_VS_END);
			end
			assert (pix_de === exp_de)
			else report_error($sformatf("pix_de %b, expected %b at line %0d pixel %0d",
				pix_de, exp_de, vpos, hpos));
			assert (hsync === exp_hs)
			else report_error($sformatf("hsync %b, expected %b at line %0d pixel %0d",
				hsync, exp_hs, vpos, hpos));
			assert (vsync === exp_vs)
			else report_error($sformatf("vsync %b, expected %b at line %0d pixel %0d",
				vsync, exp_vs, vpos, hpos));
			// read requests only inside an enabled frame fetch
			if (mem_req === 1'b1) begin
				assert (fetch_on && fetch_idx < FRAME_WORDS)
				else report_error("memory read issued outside a frame fetch");
				assert (mem_addr === fetch_base + vid_addr_t'(fetch_idx))
				else report_error($sformatf("mem_addr %h, expected %h", mem_addr,
					fetch_base + vid_addr_t'(fetch_idx)));
				fetch_idx = fetch_idx + 1;
			end
			if (exp_de) begin
				n = vpos * `VID_H_ACTIVE + hpos;
				if (disp_on) begin
					waddr = disp_base + vid_addr_t'(n / PIX_PER_WORD);
					exp_pix = lane_of(mem[waddr[7:0]], n % PIX_PER_WORD);
				end else begin
					// without a fetch every word is missing
					exp_pix = '0;
					exp_uf = 1'b1;
				end
				assert (pixel === exp_pix)
				else report_error($sformatf("pixel %h, expected %h at line %0d pixel %0d",
					pixel, exp_pix, vpos, hpos));
			end
			assert (underflow === exp_uf)
			else report_error($sformatf("underflow %b, expected %b", underflow, exp_uf));
		end
	end

	// ========================================
	// test sequence
	// ========================================

	// step one falling edge at a time to a raster position at the output
	task automatic wait_raster_pos(input int target);
		int guard;
		guard = 0;
		@(negedge rclk);
		while ((clk_count - 2) != target) begin
			guard = guard + 1;
			if (guard > WAIT_LIMIT) begin
				stop_with_failure($sformatf("Timeout waiting for raster position %0d", target));
			end
			@(negedge rclk);
		end
	endtask

	initial begin : run_test
		enable = 1'b1;
		frame_base = BASE_A;
		// first falling edge after reset release
		wait_raster_pos(-1);
		assert (mem_req === 1'b0 && pix_de === 1'b0 && hsync === 1'b0
			&& vsync === 1'b0 && underflow === 1'b0)
		else report_error("outputs not idle after reset");
		// frames 1 and 2 use the first base and frame 3 onward the new one
		wait_raster_pos(2 * FRAME_CYC + 2 * `VID_H_TOTAL);
		frame_base = BASE_B;
		// fetch stops so frame 5 runs dry
		wait_raster_pos(4 * FRAME_CYC + 2 * `VID_H_TOTAL);
		enable = 1'b0;
		wait_raster_pos(6 * FRAME_CYC + 1);
		assert (underflow === 1'b1)
		else report_error("underflow not set after fetch was stopped");
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/video_pkg.sv
video_fifo/video_fifo.sv
rtl/video_fetch.sv
rtl/video_timing.sv
rtl/pixel_shifter.sv
rtl/video_top.sv
tb/tb_clock.sv
tb/tb_video_top.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the video scan-out testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_video_top -f all.f -o sim_video \
	|| { echo "build failed"; exit 1; }

./obj_dir/sim_video > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log

[ -s sim.log ] || { echo "simulation produced no output"; exit 1; }

grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }

echo "simulation passed"
exit 0
